/* run_sim.sh */
#!/bin/sh
# build and run the spu_mac_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_spu_mac_core -f sources.f; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_spu_mac_core)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed!"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* sources.f */
spu_cfg_pkg.sv
spu_cmd_pkg.sv
spu_delay.sv
spu_elem_counter.sv
spu_sequencer.sv
spu_op_mul.sv
spu_accum.sv
spu_mac_core.sv
tb_spu_mac_core.sv

/* spu_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_accum
    import spu_cfg_pkg::*;
    (
        input  var logic  clk,
        input  var logic  reset,
        input  var logic  prod_valid,
        input  var logic  out_last,
        input  var prod_t prod_data,
        output logic      sum_valid,
        output sum_t      sum_data
    );

    sum_t acc;                                          // running sum of this run
    sum_t acc_next;

    assign acc_next = acc + sum_t'(prod_data);          // sign extended, wraps mod 2^24

    always_ff @(posedge clk) begin
        if (reset) begin
            acc       <= '0;
            sum_valid <= 1'b0;
        end
        else begin
            sum_valid <= prod_valid && out_last;
            if (prod_valid) begin
                acc <= out_last ? '0 : acc_next;        // clear for the next run
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid && out_last) begin
            sum_data <= acc_next;                       // final product included
        end
    end

    // one last element per run, and runs never overlap
    a_single_sum: assert property (
        @(posedge clk) disable iff (reset) sum_valid |=> !sum_valid
    ) else $error("sum_valid on two consecutive cycles");

endmodule

`default_nettype wire

/* spu_cfg_pkg.sv */
package spu_cfg_pkg;

    // ----------------------------------------------------------------------
    //  data path widths
    // ----------------------------------------------------------------------

    localparam int DATA_BITS  = 8;                      // operand width
    localparam int PROD_BITS  = 16;                     // full signed product
    localparam int SUM_BITS   = 24;                     // run sum, wraps
    localparam int SHIFT_BITS = 4;                      // right shift 0..15
    localparam int LEN_BITS   = 8;                      // element count minus one

    // ----------------------------------------------------------------------
    //  data words
    // ----------------------------------------------------------------------

    typedef logic signed [DATA_BITS-1:0] operand_t;     // stream or immediate operand
    typedef logic signed [PROD_BITS-1:0] prod_t;        // shifted product
    typedef logic signed [SUM_BITS-1:0]  sum_t;         // accumulated products

endpackage

/* spu_cmd_pkg.sv */
package spu_cmd_pkg;

    import spu_cfg_pkg::*;

    // ----------------------------------------------------------------------
    //  run command, taken on a single-cycle strobe
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic [LEN_BITS-1:0]   len;                     // elements minus one
        logic [SHIFT_BITS-1:0] shift;                   // arithmetic right shift
        logic                  use_imm;                 // second operand from imm
        operand_t              imm;                     // immediate operand
    } spu_cmd_t;

    // ----------------------------------------------------------------------
    //  per-element flags, travel alongside the product
    // ----------------------------------------------------------------------

    typedef struct packed {
        logic valid;                                    // element present
        logic clear;                                    // emit zero
        logic last;                                     // final element of run
    } elem_tag_t;

    typedef enum logic [1:0] {
        IDLE,                                           // waiting for a command
        RUN,                                            // taking elements
        DRAIN                                           // waiting for the sum
    } seq_state_t;

endpackage

/* spu_delay.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_delay
    #(
        parameter int  DEPTH     = 2,                   // at least one stage
        parameter type payload_t = logic
    )
    (
        input  var logic     clk,
        input  var logic     reset,
        input  var payload_t in_data,
        output payload_t     out_data
    );

    payload_t stage [DEPTH];                            // stage 0 is nearest the input

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;                         // no stray valid flags
            end
        end
        else begin
            stage[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out_data = stage[DEPTH-1];

endmodule

`default_nettype wire

/* spu_elem_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_elem_counter
    import spu_cfg_pkg::*;
    (
        input  var logic                clk,
        input  var logic                reset,
        input  var logic                load,
        input  var logic [LEN_BITS-1:0] load_value,
        input  var logic                dec,
        output logic                    last
    );

    logic [LEN_BITS-1:0] count;                         // remaining elements minus one
    logic                spent;                         // final element taken, no reload yet

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end
        else if (load) begin
            count <= load_value;
        end
        else if (dec) begin
            count <= count - 1'b1;                      // wraps after the final element
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            spent <= 1'b0;
        end
        else if (load) begin
            spent <= 1'b0;
        end
        else if (dec && last) begin
            spent <= 1'b1;
        end
    end

    assign last = (count == '0);                        // next dec takes the final element

    // ----------------------------------------------------------------------
    //  once the final element is taken, the sequencer must stop
    //  decrementing until the next command reloads the count
    // ----------------------------------------------------------------------

    property no_dec_past_last;
        @(posedge clk) disable iff (reset)
            spent |-> (!dec || load);
    endproperty

    a_no_dec_past_last: assert property (no_dec_past_last)
        else $error("element counter decremented past the final element");

endmodule

`default_nettype wire

/* spu_mac_core.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_mac_core
    import spu_cfg_pkg::*, spu_cmd_pkg::*;
    #(
        parameter int LATENCY = 3                       // accepted strobe to prod_valid
    )
    (
        input  var logic     clk,
        input  var logic     reset,
        input  var logic     cmd_valid,
        input  var spu_cmd_t cmd,
        input  var logic     in_valid,
        input  var operand_t in_data0,
        input  var operand_t in_data1,
        input  var logic     in_clear,
        output logic         busy,
        output logic         prod_valid,
        output prod_t        prod_data,
        output logic         sum_valid,
        output sum_t         sum_data
    );

    logic      cnt_load;
    logic      cnt_dec;
    logic      cnt_last;
    spu_cmd_t  run_cmd;
    elem_tag_t tag;
    operand_t  op_data0;
    operand_t  op_data1;
    logic      out_last;

    // ----------------------------------------------------------------------
    //  control
    // ----------------------------------------------------------------------

    spu_sequencer sequencer_inst (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .in_valid  (in_valid),
        .in_data0  (in_data0),
        .in_data1  (in_data1),
        .in_clear  (in_clear),
        .cnt_last  (cnt_last),
        .sum_valid (sum_valid),             // ends the run
        .cnt_load  (cnt_load),
        .cnt_dec   (cnt_dec),
        .busy      (busy),
        .run_cmd   (run_cmd),
        .tag       (tag),
        .op_data0  (op_data0),
        .op_data1  (op_data1)
    );

    spu_elem_counter elem_counter_inst (
        .clk        (clk),
        .reset      (reset),
        .load       (cnt_load),
        .load_value (cmd.len),              // loaded only with an accepted command
        .dec        (cnt_dec),
        .last       (cnt_last)
    );

    // ----------------------------------------------------------------------
    //  data path
    // ----------------------------------------------------------------------

    spu_op_mul #(
        .LATENCY (LATENCY)
    ) op_mul_inst (
        .clk        (clk),
        .reset      (reset),
        .run_cmd    (run_cmd),
        .tag        (tag),
        .op_data0   (op_data0),
        .op_data1   (op_data1),
        .prod_valid (prod_valid),
        .out_last   (out_last),
        .prod_data  (prod_data)
    );

    spu_accum accum_inst (
        .clk        (clk),
        .reset      (reset),
        .prod_valid (prod_valid),
        .out_last   (out_last),
        .prod_data  (prod_data),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data)
    );

endmodule

`default_nettype wire

/* spu_op_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_op_mul
    import spu_cfg_pkg::*, spu_cmd_pkg::*;
    #(
        parameter int LATENCY = 3                       // total, input register included
    )
    (
        input  var logic      clk,
        input  var logic      reset,
        input  var spu_cmd_t  run_cmd,
        input  var elem_tag_t tag,
        input  var operand_t  op_data0,
        input  var operand_t  op_data1,
        output logic          prod_valid,
        output logic          out_last,
        output prod_t         prod_data
    );

    localparam int DEPTH = LATENCY - 1;                 // the sequencer holds stage 1

    operand_t  op_b;                                    // selected second operand
    prod_t     full_prod;
    prod_t     shifted;
    prod_t     result;
    elem_tag_t tag_out;

    // ----------------------------------------------------------------------
    //  operand select, multiply, shift, clear
    // ----------------------------------------------------------------------

    assign op_b      = run_cmd.use_imm ? run_cmd.imm : op_data1;
    assign full_prod = prod_t'(op_data0) * prod_t'(op_b);   // both sign extended
    assign shifted   = full_prod >>> run_cmd.shift;     // arithmetic, truncates toward -inf
    assign result    = tag.clear ? '0 : shifted;

    // ----------------------------------------------------------------------
    //  result and tag travel in lock step
    // ----------------------------------------------------------------------

    spu_delay #(
        .DEPTH     (DEPTH),
        .payload_t (prod_t)
    ) prod_delay_inst (
        .clk      (clk),
        .reset    (reset),
        .in_data  (result),
        .out_data (prod_data)
    );

    spu_delay #(
        .DEPTH     (DEPTH),
        .payload_t (elem_tag_t)
    ) tag_delay_inst (
        .clk      (clk),
        .reset    (reset),
        .in_data  (tag),
        .out_data (tag_out)
    );

    assign prod_valid = tag_out.valid;
    assign out_last   = tag_out.valid && tag_out.last;

    initial begin
        if (LATENCY < 2) begin
            $fatal(1, "spu_op_mul needs LATENCY of 2 or more");
        end
    end

endmodule

`default_nettype wire

/* spu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module spu_sequencer
    import spu_cfg_pkg::*, spu_cmd_pkg::*;
    (
        input  var logic     clk,
        input  var logic     reset,
        input  var logic     cmd_valid,
        input  var spu_cmd_t cmd,
        input  var logic     in_valid,
        input  var operand_t in_data0,
        input  var operand_t in_data1,
        input  var logic     in_clear,
        input  var logic     cnt_last,
        input  var logic     sum_valid,
        output logic         cnt_load,
        output logic         cnt_dec,
        output logic         busy,
        output spu_cmd_t     run_cmd,
        output elem_tag_t    tag,
        output operand_t     op_data0,
        output operand_t     op_data1
    );

    seq_state_t state;
    logic       accept;                                 // element taken this cycle

    assign cnt_load = (state == IDLE) && cmd_valid;     // busy commands are dropped
    assign accept   = (state == RUN) && in_valid;
    assign cnt_dec  = accept;
    assign busy     = (state != IDLE);

    // ----------------------------------------------------------------------
    //  run state machine
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end
        else begin
            case (state)
                IDLE:    if (cmd_valid) state <= RUN;
                RUN:     if (accept && cnt_last) state <= DRAIN;
                DRAIN:   if (sum_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_load) begin
            run_cmd <= cmd;                             // held for the whole run
        end
    end

    // input register, stage 1 of the product latency
    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end
        else begin
            tag.valid <= accept;
            tag.clear <= accept && in_clear;
            tag.last  <= accept && cnt_last;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_data0 <= in_data0;
            op_data1 <= in_data1;
        end
    end

    // the sum comes back only after the last element went down the pipe
    a_sum_in_drain: assert property (
        @(posedge clk) disable iff (reset) sum_valid |-> (state == DRAIN)
    ) else $error("sum_valid outside of DRAIN");

endmodule

`default_nettype wire

/* tb_spu_mac_core.sv */
`timescale 1ns/1ps

module tb_spu_mac_core
    import spu_cfg_pkg::*, spu_cmd_pkg::*;
    ();

    localparam int LATENCY      = 3;
    localparam int IDLE_TIMEOUT = 64;                   // cycles allowed for the drain
    localparam int SEED         = 32'hc64e_08f3;

    typedef struct packed {
        int value;                                      // expected word
        int due;                                        // cycle it must appear in
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      cmd_valid;
    spu_cmd_t  cmd;
    logic      in_valid;
    operand_t  in_data0;
    operand_t  in_data1;
    logic      in_clear;
    logic      busy;
    logic      prod_valid;
    prod_t     prod_data;
    logic      sum_valid;
    sum_t      sum_data;

    // model state
    seq_state_t m_state;
    spu_cmd_t   m_cmd;
    int         m_left;                                 // elements still to accept
    sum_t       m_sum;
    int         cycle;
    int         drain_end;
    expect_t    prod_q [$];
    expect_t    sum_q [$];

    int   errors;
    int   tests;
    int   passed;
    int   test_start_errors;
    logic timed_out;                                    // DUT never left busy

    always #4 clk = ~clk;                               // 8 ns period

    spu_mac_core #(
        .LATENCY (LATENCY)
    ) spu_mac_core_inst (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .in_valid   (in_valid),
        .in_data0   (in_data0),
        .in_data1   (in_data1),
        .in_clear   (in_clear),
        .busy       (busy),
        .prod_valid (prod_valid),
        .prod_data  (prod_data),
        .sum_valid  (sum_valid),
        .sum_data   (sum_data)
    );

    task automatic check_value(string name, int got, int expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, expected);
            errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    //  reference rules
    // ----------------------------------------------------------------------

    function automatic int expected_product(spu_cmd_t c, operand_t a, operand_t b, logic clr);
        int opb;
        int full;
        if (clr) begin
            return 0;                                   // cleared element
        end
        opb  = c.use_imm ? int'(c.imm) : int'(b);
        full = int'(a) * opb;
        return full >>> c.shift;                        // arithmetic shift
    endfunction

    function automatic operand_t random_operand();
        int bitpos;
        bitpos = $urandom_range(7);
        case ($urandom_range(6))
            0:       return operand_t'(8'h00);
            1:       return operand_t'(8'hff);
            2:       return operand_t'(8'h80);          // signed minimum
            3:       return operand_t'(8'h7f);          // signed maximum
            4:       return operand_t'(1 << bitpos);
            5:       return operand_t'(~(1 << bitpos));
            default: return operand_t'($urandom);
        endcase
    endfunction

    // ----------------------------------------------------------------------
    //  model and monitor, sampled on the same edge as the DUT
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        int      p;
        expect_t e;
        if (reset) begin
            m_state = IDLE;
            m_sum   = '0;
            cycle   = 0;
            prod_q.delete();
            sum_q.delete();
        end
        else begin
            cycle++;
            check_value("busy", int'(busy), int'(m_state != IDLE));
            if (prod_valid) begin
                if (prod_q.size() == 0) begin
                    $display("prod_valid at %0t ns with no element in flight", $time);
                    errors++;
                end
                else begin
                    e = prod_q.pop_front();
                    check_value("prod_data", int'(prod_data), e.value);
                    check_value("prod_valid cycle", cycle, e.due);
                end
            end
            if (sum_valid) begin
                if (sum_q.size() == 0) begin
                    $display("sum_valid at %0t ns with no run waiting for its sum", $time);
                    errors++;
                end
                else begin
                    e = sum_q.pop_front();
                    check_value("sum_data", int'(sum_data), e.value);
                    check_value("sum_valid cycle", cycle, e.due);
                end
            end
            case (m_state)
                IDLE: begin
                    if (cmd_valid) begin
                        m_cmd   = cmd;
                        m_left  = int'(cmd.len) + 1;
                        m_state = RUN;
                    end
                end
                RUN: begin
                    if (in_valid) begin
                        p = expected_product(m_cmd, in_data0, in_data1, in_clear);
                        prod_q.push_back('{value: p, due: cycle + LATENCY});
                        m_sum = m_sum + sum_t'(p);      // wraps mod 2^24
                        m_left--;
                        if (m_left == 0) begin
                            sum_q.push_back('{value: int'(m_sum), due: cycle + LATENCY + 1});
                            drain_end = cycle + LATENCY + 1;
                            m_sum     = '0;
                            m_state   = DRAIN;
                        end
                    end
                end
                default: begin
                    if (cycle == drain_end) begin
                        m_state = IDLE;                 // leaves on the sum strobe
                    end
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    //  stimulus, always entered just after a rising edge
    // ----------------------------------------------------------------------

    task automatic drive_element(int clear_pct);
        in_valid <= 1'b1;
        in_data0 <= random_operand();
        in_data1 <= random_operand();
        in_clear <= ($urandom_range(99) < clear_pct);
    endtask

    task automatic run_one(int len, int shift, bit use_imm, int clear_pct, bit noise);
        spu_cmd_t c;
        spu_cmd_t stray;
        int       sent;
        int       step;
        int       waited;
        if (timed_out) begin
            return;                                     // DUT stuck, later runs skipped
        end
        c.len     = LEN_BITS'(len);
        c.shift   = SHIFT_BITS'(shift);
        c.use_imm = use_imm;
        c.imm     = random_operand();
        if (noise) begin
            repeat (3) begin
                drive_element(0);                       // idle strobes, dropped
                @(posedge clk);
            end
        end
        in_valid  <= 1'b0;
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        sent = 0;
        step = 0;
        while (sent <= len) begin
            if ($urandom_range(99) < 70) begin
                drive_element(clear_pct);
                sent++;
            end
            else begin
                in_valid <= 1'b0;
            end
            if (noise && step == 2) begin
                stray.len     = LEN_BITS'($urandom);
                stray.shift   = SHIFT_BITS'($urandom);
                stray.use_imm = ~use_imm;
                stray.imm     = random_operand();
                cmd_valid <= 1'b1;                      // must be ignored
                cmd       <= stray;
            end
            else begin
                cmd_valid <= 1'b0;
            end
            @(posedge clk);
            step++;
        end
        cmd_valid <= 1'b0;
        waited = 0;
        do begin
            if (noise) begin
                drive_element(0);                       // draining strobes, dropped
            end
            else begin
                in_valid <= 1'b0;
            end
            @(posedge clk);
            waited++;
        end while (busy && waited < IDLE_TIMEOUT);
        in_valid <= 1'b0;
        if (busy) begin
            $display("timeout: busy stayed high %0d cycles after the last element", waited);
            timed_out = 1'b1;
            errors++;
        end
        else begin
            check_value("products left over", prod_q.size(), 0);
            check_value("sums left over", sum_q.size(), 0);
        end
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(string name);
        tests++;
        if (errors == test_start_errors) begin
            passed++;
            $display("test %0d %s: ok", tests, name);
        end
        else begin
            $display("test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        in_valid  = 1'b0;
        in_data0  = '0;
        in_data1  = '0;
        in_clear  = 1'b0;
        errors    = 0;
        tests     = 0;
        passed    = 0;
        timed_out = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("busy after reset", int'(busy), 0);

        start_test();
        repeat (20) run_one($urandom_range(31), 0, 1'b0, 0, 1'b0);
        finish_test("streamed operands");

        start_test();
        repeat (12) run_one($urandom_range(31), $urandom_range(15), 1'b1, 0, 1'b0);
        finish_test("immediate operand with shift");

        start_test();
        repeat (10) run_one($urandom_range(31), $urandom_range(15), 1'($urandom), 40, 1'b0);
        finish_test("clear flag");

        start_test();
        repeat (10) run_one(4 + $urandom_range(20), $urandom_range(15), 1'($urandom), 20, 1'b1);
        finish_test("dropped strobes");

        start_test();
        run_one(0, 0, 1'b0, 0, 1'b0);                   // single element
        run_one(255, $urandom_range(15), 1'b0, 10, 1'b0);
        run_one(0, 3, 1'b1, 0, 1'b0);
        run_one(255, 0, 1'b1, 0, 1'b0);
        finish_test("run boundary");

        $display("%0d of %0d tests passed, %0d errors", passed, tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end
        else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
